//--- uno_player_settings.svh
`ifndef UNO_PLAYER_SETTINGS_SVH
`define UNO_PLAYER_SETTINGS_SVH

// widths
`define UNO_CARD_W      6
`define UNO_IDX_W       6   // holds 0..32
`define UNO_SCORE_W     11

`define UNO_HAND_MAX    32
`define UNO_INIT_DRAW   7

// card codes
`define UNO_EMPTY       6'h3F
`define UNO_WILD        4'd13
`define UNO_WILD4       4'd14
`define UNO_ACTION_MIN  4'd10

// penalty points
`define UNO_ACTION_PTS  11'd20
`define UNO_WILD_PTS    11'd50

`endif

//--- uno_pkg.sv
`include "uno_player_settings.svh"

package uno_pkg;

    typedef logic [`UNO_CARD_W-1:0]  card_t;
    typedef logic [1:0]              color_t;   // top bits of a card
    typedef logic [3:0]              value_t;   // low bits of a card
    typedef logic [`UNO_IDX_W-1:0]   hand_idx_t;
    typedef logic [`UNO_SCORE_W-1:0] score_t;

    // player turn
    typedef enum logic [2:0] {
        T_IDLE,
        T_DRAW,     // forced or initial draw
        T_PLAY,
        T_CHOOSE,   // wild colour pick
        T_OUT,
        T_NOCARD,
        T_CHECK
    } turn_state_t;

    // one move per button press
    typedef enum logic {
        C_WAIT,
        C_HELD
    } cursor_state_t;

endpackage

//--- uno_hand_store.sv
`timescale 1ns/1ps
`include "uno_player_settings.svh"

module uno_hand_store
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_add,
    input  card_t     i_add_card,
    input  logic      i_remove,
    input  hand_idx_t i_rd_idx,
    output card_t     o_rd_card,
    output hand_idx_t o_count,
    output score_t    o_score
);

    card_t     hand [`UNO_HAND_MAX];
    hand_idx_t count_r;
    hand_idx_t last_idx;
    score_t    score_r;
    card_t     sel_card;
    logic      full;
    logic      in_hand;
    logic      do_add;
    logic      do_remove;

    function automatic score_t card_points(input card_t c);
        value_t v;
        v = c[3:0];
        if (v == `UNO_WILD || v == `UNO_WILD4) begin
            card_points = `UNO_WILD_PTS;
        end else if (v >= `UNO_ACTION_MIN) begin
            card_points = `UNO_ACTION_PTS;
        end else begin
            card_points = score_t'(v);  // face value
        end
    endfunction

    assign full      = (count_r == hand_idx_t'(`UNO_HAND_MAX));
    assign in_hand   = (i_rd_idx < count_r);
    assign do_add    = i_add && !full;      // full hand drops the card
    assign do_remove = i_remove && in_hand;
    assign last_idx  = count_r - 1'b1;

    assign sel_card  = hand[i_rd_idx[`UNO_IDX_W-2:0]];
    assign o_rd_card = in_hand ? sel_card : `UNO_EMPTY;
    assign o_count   = count_r;
    assign o_score   = score_r;

    // card array in arrival order with the gap closed on removal
    always_ff @(posedge i_clk) begin
        if (do_remove) begin
            for (int i = 0; i < `UNO_HAND_MAX - 1; i++) begin
                if (i >= i_rd_idx && i < last_idx) begin
                    hand[i] <= hand[i + 1];
                end
            end
            hand[last_idx[`UNO_IDX_W-2:0]] <= `UNO_EMPTY;
        end else if (do_add) begin
            hand[count_r[`UNO_IDX_W-2:0]] <= i_add_card;   // append at tail
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_r <= '0;
            score_r <= '0;
        end else if (do_remove) begin
            count_r <= last_idx;
            score_r <= score_r - card_points(sel_card);
        end else if (do_add) begin
            count_r <= count_r + 1'b1;
            score_r <= score_r + card_points(i_add_card);
        end
    end

endmodule

//--- uno_cursor.sv
`timescale 1ns/1ps
`include "uno_player_settings.svh"

module uno_cursor
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_left,
    input  logic      i_right,
    input  logic      i_color_mode,
    input  hand_idx_t i_count,
    output hand_idx_t o_index
);

    cursor_state_t state_r;
    cursor_state_t state_nxt;
    hand_idx_t     idx_r;
    hand_idx_t     idx_nxt;
    hand_idx_t     top;
    hand_idx_t     left_pos;
    hand_idx_t     right_pos;
    logic          mode_q;
    logic          press;

    // last position is the no-card slot or blue in colour mode
    assign top       = i_color_mode ? hand_idx_t'(3) : i_count;
    assign left_pos  = (idx_r == '0) ? top : idx_r - 1'b1;
    assign right_pos = (idx_r >= top) ? '0 : idx_r + 1'b1;
    assign press     = i_left || i_right;
    assign o_index   = idx_r;

    always_comb begin
        state_nxt = state_r;
        idx_nxt   = idx_r;
        if (i_color_mode != mode_q) begin
            idx_nxt = '0;       // entering or leaving colour pick
        end else if (state_r == C_WAIT && press) begin
            state_nxt = C_HELD;
            idx_nxt   = i_left ? left_pos : right_pos;
        end else if (!i_color_mode && idx_r > i_count) begin
            idx_nxt = i_count;  // hand shrank under the cursor
        end

        // wait for release before the next move
        if (state_r == C_HELD && !press) begin
            state_nxt = C_WAIT;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= C_WAIT;
            idx_r   <= '0;
            mode_q  <= 1'b0;
        end else begin
            state_r <= state_nxt;
            idx_r   <= idx_nxt;
            mode_q  <= i_color_mode;
        end
    end

endmodule

//--- uno_turn_ctrl.sv
`timescale 1ns/1ps
`include "uno_player_settings.svh"

module uno_turn_ctrl
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_init,
    input  logic      i_start,
    input  logic      i_draw_two,
    input  logic      i_draw_four,
    input  logic      i_drawn,
    input  logic      i_check,
    input  logic      i_select,
    input  card_t     i_drawed_card,
    input  card_t     i_prev_card,
    input  card_t     i_cursor_card,
    input  hand_idx_t i_index,
    output logic      o_add,
    output logic      o_remove,
    output logic      o_draw,
    output logic      o_out,
    output logic      o_select,
    output card_t     o_out_card
);

    turn_state_t state_r;
    turn_state_t state_nxt;
    logic [2:0]  draw_cnt_r;
    logic [2:0]  draw_cnt_nxt;
    card_t       out_card_r;
    card_t       out_card_nxt;
    logic        sel_q;
    logic        sel_rise;
    color_t      cur_color;
    color_t      prev_color;
    value_t      cur_value;
    value_t      prev_value;
    logic        is_empty;
    logic        is_wild;
    logic        is_legal;

    assign cur_color  = i_cursor_card[5:4];
    assign cur_value  = i_cursor_card[3:0];
    assign prev_color = i_prev_card[5:4];
    assign prev_value = i_prev_card[3:0];

    assign is_empty = (i_cursor_card == `UNO_EMPTY);
    assign is_wild  = (cur_value == `UNO_WILD) || (cur_value == `UNO_WILD4);
    assign is_legal = (cur_color == prev_color) || (cur_value == prev_value);
    assign sel_rise = i_select && !sel_q;   // one action per press

    // dealer card goes straight into the hand
    assign o_add      = i_drawn && (state_r == T_DRAW || state_r == T_NOCARD);
    assign o_draw     = (state_r == T_NOCARD);
    assign o_out      = (state_r == T_OUT);
    assign o_select   = (state_r == T_CHOOSE);
    assign o_out_card = out_card_r;

    always_comb begin
        state_nxt    = state_r;
        draw_cnt_nxt = draw_cnt_r;
        out_card_nxt = out_card_r;
        o_remove     = 1'b0;
        case (state_r)
            T_IDLE: begin
                if (i_start) begin
                    if (i_draw_two) begin
                        state_nxt    = T_DRAW;
                        draw_cnt_nxt = 3'd2;
                    end else if (i_draw_four) begin
                        state_nxt    = T_DRAW;
                        draw_cnt_nxt = 3'd4;
                    end else begin
                        state_nxt = T_PLAY;
                    end
                end else if (i_init) begin
                    state_nxt    = T_DRAW;
                    draw_cnt_nxt = 3'(`UNO_INIT_DRAW);  // deal
                end
            end
            T_DRAW: begin
                if (i_drawn) begin
                    draw_cnt_nxt = draw_cnt_r - 1'b1;
                    if (draw_cnt_r <= 3'd1) begin
                        state_nxt = i_start ? T_PLAY : T_IDLE;
                    end
                end
            end
            T_PLAY: begin
                if (sel_rise) begin
                    if (is_empty) begin
                        state_nxt = T_NOCARD;
                    end else if (is_wild) begin
                        state_nxt    = T_CHOOSE;
                        o_remove     = 1'b1;
                        out_card_nxt = {color_t'(0), cur_value};
                    end else if (is_legal) begin
                        state_nxt    = T_OUT;
                        o_remove     = 1'b1;
                        out_card_nxt = i_cursor_card;
                    end
                end
            end
            T_CHOOSE: begin
                if (sel_rise) begin
                    state_nxt    = T_OUT;
                    out_card_nxt = {color_t'(i_index[1:0]), out_card_r[3:0]};
                end
            end
            T_OUT: begin
                if (i_check) begin
                    state_nxt = T_IDLE;
                end
            end
            T_NOCARD: begin
                if (i_drawn) begin
                    state_nxt = T_CHECK;
                end
            end
            T_CHECK: begin
                if (i_check) begin
                    state_nxt = T_IDLE;
                end
            end
            default: begin
                state_nxt = T_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= T_IDLE;
            draw_cnt_r <= '0;
            out_card_r <= '0;
            sel_q      <= 1'b0;
        end else begin
            state_r    <= state_nxt;
            draw_cnt_r <= draw_cnt_nxt;
            out_card_r <= out_card_nxt;
            sel_q      <= i_select;
        end
    end

endmodule

//--- uno_player.sv
`timescale 1ns/1ps
`include "uno_player_settings.svh"

module uno_player
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_init,
    input  logic      i_start,
    input  logic      i_draw_two,
    input  logic      i_draw_four,
    input  card_t     i_prev_card,
    input  logic      i_drawn,
    input  card_t     i_drawed_card,
    input  logic      i_check,
    input  logic      i_left,
    input  logic      i_right,
    input  logic      i_select,
    output logic      o_draw,
    output logic      o_out,
    output card_t     o_out_card,
    output hand_idx_t o_index,
    output card_t     o_cursor_card,
    output hand_idx_t o_hand_num,
    output score_t    o_score,
    output logic      o_select
);

    logic      add;
    logic      remove;
    hand_idx_t index;
    hand_idx_t count;
    card_t     cursor_card;

    assign o_index       = index;
    assign o_hand_num    = count;
    assign o_cursor_card = cursor_card;

    uno_turn_ctrl u_turn (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_drawn       (i_drawn),
        .i_check       (i_check),
        .i_select      (i_select),
        .i_drawed_card (i_drawed_card),
        .i_prev_card   (i_prev_card),
        .i_cursor_card (cursor_card),
        .i_index       (index),
        .o_add         (add),
        .o_remove      (remove),
        .o_draw        (o_draw),
        .o_out         (o_out),
        .o_select      (o_select),
        .o_out_card    (o_out_card)
    );

    uno_hand_store u_hand (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_add      (add),
        .i_add_card (i_drawed_card),
        .i_remove   (remove),
        .i_rd_idx   (index),
        .o_rd_card  (cursor_card),
        .o_count    (count),
        .o_score    (o_score)
    );

    // colour mode follows the wild colour pick
    uno_cursor u_cursor (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_left       (i_left),
        .i_right      (i_right),
        .i_color_mode (o_select),
        .i_count      (count),
        .o_index      (index)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

//--- uno_player_chk.sv
`timescale 1ns/1ps
`include "uno_player_settings.svh"

module uno_player_chk
    import uno_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_draw,
    input logic      i_out,
    input logic      i_select,
    input logic      i_check,
    input card_t     i_out_card,
    input hand_idx_t i_hand_num
);

    int unsigned fail_cnt = 0;

    a_out_draw: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_out && i_draw))
        else begin
            $error("o_out and o_draw high together");
            fail_cnt++;
        end

    a_out_select: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_out && i_select))
        else begin
            $error("o_select high during o_out");
            fail_cnt++;
        end

    // card held until the table acknowledges
    a_out_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_out && !i_check) |=> $stable(i_out_card))
        else begin
            $error("o_out_card changed while o_out waits for i_check");
            fail_cnt++;
        end

    a_hand_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_hand_num <= hand_idx_t'(`UNO_HAND_MAX))
        else begin
            $error("o_hand_num above hand capacity");
            fail_cnt++;
        end

endmodule

bind uno_player uno_player_chk chk0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_draw     (o_draw),
    .i_out      (o_out),
    .i_select   (o_select),
    .i_check    (i_check),
    .i_out_card (o_out_card),
    .i_hand_num (o_hand_num)
);

//--- tb_uno_player.sv
`timescale 1ns/1ps
`include "uno_player_settings.svh"

module tb_uno_player
    import uno_pkg::*;
();

    localparam int N_STEPS     = 6;
    localparam int STEP_CYCLES = 200;
    localparam int CLK_PERIOD  = 4;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_init;
    logic      i_start;
    logic      i_draw_two;
    logic      i_draw_four;
    logic      i_drawn;
    logic      i_check;
    logic      i_left;
    logic      i_right;
    logic      i_select;
    card_t     i_prev_card;
    card_t     i_drawed_card;
    logic      o_draw;
    logic      o_out;
    logic      o_select;
    card_t     o_out_card;
    card_t     o_cursor_card;
    hand_idx_t o_index;
    hand_idx_t o_hand_num;
    score_t    o_score;

    card_t       model[$];   // hand in arrival order
    logic [31:0] seed;
    card_t       card;
    int          k;
    int          w;
    int          n_before;
    int          score_before;

    tb_clkgen #(.PERIOD(CLK_PERIOD)) clk0 (.o_clk(i_clk));

    uno_player dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_prev_card   (i_prev_card),
        .i_drawn       (i_drawn),
        .i_drawed_card (i_drawed_card),
        .i_check       (i_check),
        .i_left        (i_left),
        .i_right       (i_right),
        .i_select      (i_select),
        .o_draw        (o_draw),
        .o_out         (o_out),
        .o_out_card    (o_out_card),
        .o_index       (o_index),
        .o_cursor_card (o_cursor_card),
        .o_hand_num    (o_hand_num),
        .o_score       (o_score),
        .o_select      (o_select)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // face value for numbers and 20 per action card and 50 per wild
    function automatic int hand_score(input card_t hand[$]);
        int sum;
        int v;
        sum = 0;
        foreach (hand[i]) begin
            v = int'(hand[i][3:0]);
            if (v >= 13)
                sum += 50;
            else if (v >= 10)
                sum += 20;
            else
                sum += v;
        end
        return sum;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int exp, input int act);
        if (exp != act) begin
            fail_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                               $time, name, exp, act));
        end
    endtask

    task automatic tick();
        @(posedge i_clk);
        #1;
    endtask

    task automatic next_card(output card_t c);
        seed = lcg_next(seed);
        c = {seed[17:16], 4'(seed[27:20] % 8'd15)};   // values 0..14
    endtask

    task automatic deliver(input card_t c);
        i_drawed_card = c;
        i_drawn = 1'b1;
        tick();
        i_drawn = 1'b0;
        tick();
    endtask

    task automatic step_right();
        i_right = 1'b1;
        tick();
        i_right = 1'b0;
        tick();
    endtask

    task automatic select_card();
        i_select = 1'b1;
        tick();
        i_select = 1'b0;
    endtask

    task automatic move_cursor(input int target);
        int n;
        n = 0;
        while (int'(o_index) != target && n <= `UNO_HAND_MAX + 1) begin
            step_right();
            n++;
        end
        check_value("o_index", target, int'(o_index));
    endtask

    // count and score after every delivered card and every played card
    initial begin : compare_proc
        logic drawn_seen;
        logic out_was;
        drawn_seen = 1'b0;
        out_was = 1'b0;
        forever begin
            @(posedge i_clk);
            #2;
            if (drawn_seen || (o_out && !out_was)) begin
                check_value("o_hand_num", model.size(), int'(o_hand_num));
                check_value("o_score", hand_score(model), int'(o_score));
            end
            drawn_seen = i_drawn;
            out_was = o_out;
        end
    end

    initial begin
        #(N_STEPS * STEP_CYCLES * CLK_PERIOD);
        fail_run("timeout: player never finished the turn");
    end

    // a failed protocol assertion ends the run at once
    initial begin
        wait (dut0.chk0.fail_cnt != 0);
        fail_run("a protocol assertion failed during the run");
    end

    initial begin
        i_rst_n = 1'b0;
        i_init = 1'b0;
        i_start = 1'b0;
        i_draw_two = 1'b0;
        i_draw_four = 1'b0;
        i_drawn = 1'b0;
        i_check = 1'b0;
        i_left = 1'b0;
        i_right = 1'b0;
        i_select = 1'b0;
        i_prev_card = '0;
        i_drawed_card = '0;
        seed = 32'hd81c;
        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;

        check_value("o_draw", 0, o_draw);
        check_value("o_out", 0, o_out);
        check_value("o_select", 0, o_select);
        check_value("o_hand_num", 0, int'(o_hand_num));
        check_value("o_score", 0, int'(o_score));
        check_value("o_index", 0, int'(o_index));

        // initial deal
        i_init = 1'b1;
        tick();
        i_init = 1'b0;
        repeat (`UNO_INIT_DRAW) begin
            next_card(card);
            model.push_back(card);
            deliver(card);
        end
        check_value("o_hand_num", 7, int'(o_hand_num));
        for (int i = 0; i < model.size(); i++) begin
            check_value("o_cursor_card", model[i], o_cursor_card);
            step_right();
        end
        check_value("o_index", model.size(), int'(o_index));
        check_value("o_cursor_card", `UNO_EMPTY, o_cursor_card);
        step_right();
        check_value("o_index", 0, int'(o_index));

        // forced draws of two then four
        n_before = model.size();
        i_start = 1'b1;
        i_draw_two = 1'b1;
        tick();
        i_start = 1'b0;
        i_draw_two = 1'b0;
        repeat (2) begin
            next_card(card);
            model.push_back(card);
            deliver(card);
        end
        check_value("o_hand_num", n_before + 2, int'(o_hand_num));
        n_before = model.size();
        i_start = 1'b1;
        i_draw_four = 1'b1;
        tick();
        i_draw_four = 1'b0;
        for (int i = 0; i < 4; i++) begin
            next_card(card);
            if (i == 3)
                card[3:0] = `UNO_WILD4;   // a wild for the colour pick later
            model.push_back(card);
            deliver(card);
        end
        i_start = 1'b0;
        check_value("o_hand_num", n_before + 4, int'(o_hand_num));
        check_value("o_score", hand_score(model), int'(o_score));

        // illegal then legal play of one card
        k = -1;
        for (int i = 0; i < model.size(); i++) begin
            if (k < 0 && model[i][3:0] < `UNO_WILD)
                k = i;
        end
        if (k < 0)
            fail_run("no coloured card in the hand to play");
        move_cursor(k);
        card = model[k];
        i_prev_card = {card[5:4] ^ 2'b01, ((card[3:0] == 4'd0) ? 4'd1 : 4'd0)};
        select_card();
        repeat (10) begin
            check_value("o_out", 0, o_out);
            check_value("o_select", 0, o_select);
            check_value("o_draw", 0, o_draw);
            tick();
        end
        i_prev_card = {card[5:4], 4'(card[3:0] + 4'd1)};   // colour match only
        model.delete(k);
        select_card();
        check_value("o_out", 1, o_out);
        check_value("o_out_card", card, o_out_card);
        tick();
        tick();
        check_value("o_out", 1, o_out);
        i_check = 1'b1;
        tick();
        i_check = 1'b0;
        check_value("o_out", 0, o_out);

        // wild with colour pick
        i_start = 1'b1;
        tick();
        i_start = 1'b0;
        w = -1;
        for (int i = 0; i < model.size(); i++) begin
            if (w < 0 && model[i][3:0] >= `UNO_WILD)
                w = i;
        end
        if (w < 0)
            fail_run("no wild card in the hand");
        move_cursor(w);
        card = model[w];
        score_before = hand_score(model);
        model.delete(w);
        select_card();
        check_value("o_select", 1, o_select);
        tick();
        tick();
        check_value("o_index", 0, int'(o_index));
        seed = lcg_next(seed);
        k = int'(seed[18:16]);
        repeat (k) step_right();
        select_card();
        check_value("o_out", 1, o_out);
        check_value("o_select", 0, o_select);
        check_value("o_out_card", {2'(k % 4), card[3:0]}, o_out_card);
        check_value("o_score", score_before - 50, int'(o_score));
        i_check = 1'b1;
        tick();
        i_check = 1'b0;

        // no-card slot and single draw
        i_start = 1'b1;
        tick();
        i_start = 1'b0;
        tick();
        check_value("o_index", 0, int'(o_index));
        i_left = 1'b1;
        tick();
        i_left = 1'b0;
        tick();
        check_value("o_index", model.size(), int'(o_index));
        check_value("o_cursor_card", `UNO_EMPTY, o_cursor_card);
        select_card();
        check_value("o_draw", 1, o_draw);
        next_card(card);
        model.push_back(card);
        deliver(card);
        check_value("o_draw", 0, o_draw);
        check_value("o_cursor_card", card, o_cursor_card);
        i_check = 1'b1;
        tick();
        i_check = 1'b0;
        next_card(card);
        deliver(card);   // ignored in idle
        check_value("o_hand_num", model.size(), int'(o_hand_num));
        tick();

        if (dut0.chk0.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_run("a protocol assertion failed during the run");
        end
    end

endmodule

//--- uno_player.f
+incdir+.
uno_pkg.sv
uno_hand_store.sv
uno_cursor.sv
uno_turn_ctrl.sv
uno_player.sv
tb_clkgen.sv
uno_player_chk.sv
tb_uno_player.sv
